// File: source/patch_pkg.sv
`default_nettype none

package patch_pkg;

  // Q8.8 signed feature and weight
  localparam int feat_w = 16;
  // Product and running sum, wraps modulo 2^32
  localparam int sum_w  = 32;
  localparam int row_w  = 10;
  localparam int col_w  = 10;

  // One tagged feature from the scanner
  typedef struct packed {
    logic signed [feat_w-1:0] value;
    logic [row_w-1:0]         row;
    logic [col_w-1:0]         col;
    logic                     valid;
  } feature_beat_t;

  // Patch position, loaded on init
  typedef struct packed {
    logic [row_w-1:0] row;
    logic [col_w-1:0] col;  // Start column
  } patch_config_t;

  // Finished patch row
  typedef struct packed {
    logic [sum_w-1:0] sum;
    logic [row_w-1:0] row;
    logic [col_w-1:0] col;
  } patch_result_t;

  typedef enum logic [2:0] {
    config_wait,
    match_wait,
    matched,
    sum_wait,
    sum_rdy
  } reducer_state_e;

endpackage

`default_nettype wire

// File: source/scan_position.sv
`timescale 1ns/1ns
`default_nettype none

module scan_position
  import patch_pkg::*;
#(
  parameter int ROW_LEN = 32
) (
  input  logic              reset,
  input  logic              dram_clk,
  input  logic [feat_w-1:0] fds,
  input  logic              fds_val_in,
  input  logic              sof,
  output feature_beat_t     beat
);

  logic [row_w-1:0] row_cnt;
  logic [col_w-1:0] col_cnt;
  logic [row_w-1:0] pos_row;
  logic [col_w-1:0] pos_col;
  logic             last_col;

  // Position of the current feature, sof restarts the frame
  assign pos_row  = sof ? '0 : row_cnt;
  assign pos_col  = sof ? '0 : col_cnt;
  assign last_col = (pos_col == col_w'(ROW_LEN - 1));

  always_ff @(posedge reset or posedge dram_clk) begin
    if (dram_clk) begin
      row_cnt <= '0;
      col_cnt <= '0;
    end else if (fds_val_in) begin
      if (last_col) begin
        row_cnt <= pos_row + 1'b1;  // Wrap to next row
        col_cnt <= '0;
      end else begin
        row_cnt <= pos_row;
        col_cnt <= pos_col + 1'b1;
      end
    end
  end

  always_ff @(posedge reset or posedge dram_clk) begin
    if (dram_clk) begin
      beat <= '0;
    end else begin
      beat.valid <= fds_val_in;
      beat.value <= fds;
      beat.row   <= pos_row;
      beat.col   <= pos_col;
    end
  end

endmodule

`default_nettype wire

// File: source/patch_weight_bank.sv
`timescale 1ns/1ns
`default_nettype none

module patch_weight_bank
  import patch_pkg::*;
#(
  parameter int  PATCH_SIZE = 8,
  localparam int idx_w      = (PATCH_SIZE > 1) ? $clog2(PATCH_SIZE) : 1
) (
  input  logic                         reset,
  input  logic                         dram_clk,
  input  logic                         load,
  input  logic [PATCH_SIZE*feat_w-1:0] weights_in,
  input  logic [idx_w-1:0]             index,
  output logic [feat_w-1:0]            weight
);

  logic [feat_w-1:0] weight_reg [PATCH_SIZE];

  // Weight i sits in slice i of weights_in
  always_ff @(posedge reset or posedge dram_clk) begin
    if (dram_clk) begin
      for (int i = 0; i < PATCH_SIZE; i++) begin
        weight_reg[i] <= '0;
      end
    end else if (load) begin
      for (int i = 0; i < PATCH_SIZE; i++) begin
        weight_reg[i] <= weights_in[i*feat_w +: feat_w];
      end
    end
  end

  // Combinational read, index never passes the last weight
  assign weight = weight_reg[index];

endmodule

`default_nettype wire

// File: source/patch_mac.sv
`timescale 1ns/1ns
`default_nettype none

module patch_mac
  import patch_pkg::*;
#(
  parameter int  PATCH_SIZE   = 8,
  parameter int  MULT_LATENCY = 3,
  localparam int cnt_w        = (PATCH_SIZE > 1) ? $clog2(PATCH_SIZE) : 1
) (
  input  logic              reset,
  input  logic              dram_clk,
  input  logic              start,
  input  logic              product_req,
  input  logic [feat_w-1:0] feature,
  input  logic [feat_w-1:0] weight,
  output logic [sum_w-1:0]  sum,
  output logic              sum_valid
);

  logic [feat_w-1:0]       feature_q;
  logic [feat_w-1:0]       weight_q;
  logic                    req_q;
  logic [sum_w-1:0]        prod_pipe [MULT_LATENCY];
  logic [MULT_LATENCY-1:0] prod_valid;
  logic [sum_w-1:0]        acc;
  logic [cnt_w-1:0]        count;

  // Valid pipeline, one stage ahead of the product pipeline
  always_ff @(posedge reset or posedge dram_clk) begin
    if (dram_clk) begin
      req_q      <= 1'b0;
      prod_valid <= '0;
    end else begin
      req_q         <= product_req;
      prod_valid[0] <= req_q;
      for (int i = 1; i < MULT_LATENCY; i++) begin
        prod_valid[i] <= prod_valid[i-1];
      end
    end
  end

  // Operand register then MULT_LATENCY product stages
  always_ff @(posedge reset) begin
    feature_q    <= feature;
    weight_q     <= weight;
    prod_pipe[0] <= $signed(feature_q) * $signed(weight_q);
    for (int i = 1; i < MULT_LATENCY; i++) begin
      prod_pipe[i] <= prod_pipe[i-1];
    end
  end

  always_ff @(posedge reset or posedge dram_clk) begin
    if (dram_clk) begin
      acc       <= '0;
      count     <= '0;
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= 1'b0;
      if (start) begin
        acc   <= '0;
        count <= '0;
      end else if (prod_valid[MULT_LATENCY-1]) begin
        acc <= acc + prod_pipe[MULT_LATENCY-1];  // Wraps mod 2^32
        if (count == cnt_w'(PATCH_SIZE - 1)) begin
          count     <= '0;
          sum_valid <= 1'b1;  // Last product of the patch
        end else begin
          count <= count + 1'b1;
        end
      end
    end
  end

  assign sum = acc;

endmodule

`default_nettype wire

// File: source/patch_row_reducer.sv
`timescale 1ns/1ns
`default_nettype none

module patch_row_reducer
  import patch_pkg::*;
#(
  parameter int  PATCH_SIZE   = 8,
  parameter int  MULT_LATENCY = 3,
  localparam int idx_w        = (PATCH_SIZE > 1) ? $clog2(PATCH_SIZE) : 1
) (
  input  logic                         reset,
  input  logic                         dram_clk,
  input  logic                         init,
  input  patch_config_t                conf,
  input  logic [PATCH_SIZE*feat_w-1:0] conf_weights,
  input  feature_beat_t                beat,
  output logic                         available,
  output logic                         done,
  output patch_result_t                result
);

  reducer_state_e    state;
  patch_config_t     cfg;
  logic [idx_w-1:0]  idx;
  logic              load;
  logic              hit;
  logic              product_req;
  logic [feat_w-1:0] weight;
  logic [sum_w-1:0]  mac_sum;
  logic              sum_valid;
  logic              last_product;

  assign load = (state == config_wait) && init;

  // First feature of the patch row
  assign hit = (state == match_wait) && beat.valid &&
               (beat.row == cfg.row) && (beat.col == cfg.col);

  assign product_req  = hit || ((state == matched) && beat.valid);
  assign last_product = (idx == idx_w'(PATCH_SIZE - 1));

  assign available = (state == config_wait);
  assign done      = (state == sum_rdy);

  patch_weight_bank #(
    .PATCH_SIZE (PATCH_SIZE)
  ) u_weight_bank (
    .reset      (reset),
    .dram_clk   (dram_clk),
    .load       (load),
    .weights_in (conf_weights),
    .index      (idx),
    .weight     (weight)
  );

  patch_mac #(
    .PATCH_SIZE   (PATCH_SIZE),
    .MULT_LATENCY (MULT_LATENCY)
  ) u_mac (
    .reset       (reset),
    .dram_clk    (dram_clk),
    .start       (load),
    .product_req (product_req),
    .feature     (beat.value),
    .weight      (weight),
    .sum         (mac_sum),
    .sum_valid   (sum_valid)
  );

  always_ff @(posedge reset or posedge dram_clk) begin
    if (dram_clk) begin
      state  <= config_wait;
      cfg    <= '0;
      idx    <= '0;
      result <= '0;
    end else begin
      case (state)
        config_wait: begin
          if (init) begin
            cfg   <= conf;
            idx   <= '0;
            state <= match_wait;
          end
        end
        match_wait, matched: begin
          if (product_req) begin
            if (last_product) begin
              idx   <= '0;  // Keep index inside the bank
              state <= sum_wait;
            end else begin
              idx   <= idx + 1'b1;
              state <= matched;
            end
          end
        end
        sum_wait: begin
          if (sum_valid) begin
            result.sum <= mac_sum;
            result.row <= cfg.row;
            result.col <= cfg.col;
            state      <= sum_rdy;
          end
        end
        sum_rdy: state <= config_wait;
        default: state <= config_wait;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/patch_reducer_top.sv
`timescale 1ns/1ns
`default_nettype none

module patch_reducer_top
  import patch_pkg::*;
#(
  parameter int PATCH_SIZE   = 8,
  parameter int ROW_LEN      = 32,
  parameter int MULT_LATENCY = 3
) (
  input  logic                         reset,
  input  logic                         dram_clk,
  input  logic [feat_w-1:0]            fds,
  input  logic                         fds_val_in,
  input  logic                         sof,
  input  logic                         init,
  input  patch_config_t                conf,
  input  logic [PATCH_SIZE*feat_w-1:0] conf_weights,
  output logic                         available,
  output logic                         done,
  output patch_result_t                result
);

  feature_beat_t beat;  // Tagged stream into the reducer

  scan_position #(
    .ROW_LEN (ROW_LEN)
  ) u_scan (
    .reset      (reset),
    .dram_clk   (dram_clk),
    .fds        (fds),
    .fds_val_in (fds_val_in),
    .sof        (sof),
    .beat       (beat)
  );

  patch_row_reducer #(
    .PATCH_SIZE   (PATCH_SIZE),
    .MULT_LATENCY (MULT_LATENCY)
  ) u_reducer (
    .reset        (reset),
    .dram_clk     (dram_clk),
    .init         (init),
    .conf         (conf),
    .conf_weights (conf_weights),
    .beat         (beat),
    .available    (available),
    .done         (done),
    .result       (result)
  );

endmodule

`default_nettype wire

// File: test/patch_reducer_properties.sv
`timescale 1ns/1ns
`default_nettype none

module patch_reducer_properties
  import patch_pkg::*;
(
  input logic           reset,
  input logic           dram_clk,
  input logic           init,
  input logic           available,
  input logic           done,
  input reducer_state_e state
);

  int prop_errors = 0;

  a_avail_done_excl: assert property (@(posedge reset) disable iff (dram_clk)
    !(available && done))
    else begin
      $error("available and done are high together");
      prop_errors++;
    end

  // One cycle in sum_rdy, then back to config_wait
  a_done_pulse: assert property (@(posedge reset) disable iff (dram_clk)
    done |=> !done && state == config_wait)
    else begin
      $error("done lasted more than one cycle");
      prop_errors++;
    end

  a_init_taken: assert property (@(posedge reset) disable iff (dram_clk)
    init && available |=> !available)
    else begin
      $error("init while available did not drop available");
      prop_errors++;
    end

endmodule

bind patch_reducer_top patch_reducer_properties u_props (
  .reset     (reset),
  .dram_clk  (dram_clk),
  .init      (init),
  .available (available),
  .done      (done),
  .state     (u_reducer.state)
);

`default_nettype wire

// File: test/patch_reducer_tb.sv
`timescale 1ns/1ns
`default_nettype none

module patch_reducer_tb
  import patch_pkg::*;
();

  localparam int patch_size     = 8;
  localparam int row_len        = 32;
  localparam int mult_latency   = 3;
  localparam int reset_cycles   = 16;
  localparam int n_frames       = 2;
  localparam int rows_per_frame = 13;
  localparam int max_cycles     = 4 * (n_frames * rows_per_frame * row_len * 2);

  logic                         reset;     // Clock
  logic                         dram_clk;  // Async reset, active high
  logic [feat_w-1:0]            fds;
  logic                         fds_val_in;
  logic                         sof;
  logic                         init;
  patch_config_t                conf;
  logic [patch_size*feat_w-1:0] conf_weights;
  logic                         available;
  logic                         done;
  patch_result_t                result;

  int seed = 87409;
  int cyc = 0;
  int errors = 0;
  int total_errors;
  int patches_expected = 0;
  int patches_seen = 0;

  // Reference model state
  logic [row_w-1:0]  m_row = '0;
  logic [col_w-1:0]  m_col = '0;
  logic [row_w-1:0]  cfg_row;
  logic [col_w-1:0]  cfg_col;
  logic [feat_w-1:0] w_model [patch_size];
  bit                armed = 1'b0;
  int                taken = 0;
  int                model_acc = 0;
  logic [sum_w-1:0]  exp_sum = '0;
  logic [row_w-1:0]  exp_row = '0;
  logic [col_w-1:0]  exp_col = '0;
  int                exp_done_cyc = 0;

  patch_reducer_top #(
    .PATCH_SIZE   (patch_size),
    .ROW_LEN      (row_len),
    .MULT_LATENCY (mult_latency)
  ) u_dut (
    .reset        (reset),
    .dram_clk     (dram_clk),
    .fds          (fds),
    .fds_val_in   (fds_val_in),
    .sof          (sof),
    .init         (init),
    .conf         (conf),
    .conf_weights (conf_weights),
    .available    (available),
    .done         (done),
    .result       (result)
  );

  initial reset = 1'b0;
  always #2 reset = ~reset;

  always @(posedge reset) cyc <= cyc + 1;

  // Counted on the edge that samples done
  always @(posedge reset) begin
    if (!dram_clk && done) patches_seen <= patches_seen + 1;
  end

  a_reset_idle: assert property (@(posedge reset) $fell(dram_clk) |-> available && !done)
    else begin
      errors++;
      $display("Error at %0t: available/done expected 1/0, got %b/%b", $time,
               $sampled(available), $sampled(done));
    end

  a_done_expected: assert property (@(posedge reset) disable iff (dram_clk)
    done |-> patches_seen < patches_expected)
    else begin
      errors++;
      $display("done pulsed at %0t while no patch was in progress", $time);
    end

  a_latency: assert property (@(posedge reset) disable iff (dram_clk)
    done |-> cyc == exp_done_cyc)
    else begin
      errors++;
      $display("Error at %0t: done cycle expected %0d, got %0d", $time, exp_done_cyc,
               $sampled(cyc));
    end

  a_sum: assert property (@(posedge reset) disable iff (dram_clk)
    done |-> result.sum == exp_sum)
    else begin
      errors++;
      $display("Error at %0t: result.sum expected %h, got %h", $time, exp_sum,
               $sampled(result.sum));
    end

  a_pos: assert property (@(posedge reset) disable iff (dram_clk)
    done |-> result.row == exp_row && result.col == exp_col)
    else begin
      errors++;
      $display("Error at %0t: result.row/col expected %0d/%0d, got %0d/%0d", $time,
               exp_row, exp_col, $sampled(result.row), $sampled(result.col));
    end

  // One feature per call, starts and ends on a falling edge
  task automatic send_feature(input logic [feat_w-1:0] value, input logic first);
    if (first) begin
      m_row = '0;
      m_col = '0;
    end
    if (armed && (taken > 0 || (m_row == cfg_row && m_col == cfg_col))) begin
      model_acc = model_acc + int'($signed(w_model[taken])) * int'($signed(value));
      taken++;
      if (taken == patch_size) begin
        exp_sum      = model_acc;
        exp_row      = cfg_row;
        exp_col      = cfg_col;
        exp_done_cyc = cyc + mult_latency + 4;  // Scanner edge plus reducer and mac stages
        patches_expected++;
        armed = 1'b0;
      end
    end
    fds        = value;
    fds_val_in = 1'b1;
    sof        = first;
    @(negedge reset);
    if (m_col == col_w'(row_len - 1)) begin
      m_col = '0;
      m_row = m_row + 1'b1;
    end else begin
      m_col = m_col + 1'b1;
    end
    fds_val_in = 1'b0;
    sof        = 1'b0;
    if ($random(seed) & 1) @(negedge reset);  // Random gap
  endtask

  task automatic stream_features(input int count, input logic new_frame);
    for (int i = 0; i < count; i++) begin
      send_feature(feat_w'($random(seed)), new_frame && (i == 0));
    end
  endtask

  task automatic configure(input logic [row_w-1:0] row, input logic [col_w-1:0] col,
                           input bit accept);
    logic [feat_w-1:0] w;
    if (accept) begin
      while (!available) @(negedge reset);
    end
    conf.row = row;
    conf.col = col;
    for (int i = 0; i < patch_size; i++) begin
      w = feat_w'($random(seed));
      conf_weights[i*feat_w +: feat_w] = w;
      if (accept) w_model[i] = w;
    end
    if (accept) begin
      cfg_row   = row;
      cfg_col   = col;
      taken     = 0;
      model_acc = 0;
      armed     = 1'b1;
    end
    init = 1'b1;
    @(negedge reset);
    init = 1'b0;
  endtask

  task automatic wait_done();
    while (patches_seen != patches_expected) @(negedge reset);
  endtask

  initial begin
    logic [col_w-1:0] col;
    fds          = '0;
    fds_val_in   = 1'b0;
    sof          = 1'b0;
    init         = 1'b0;
    conf         = '0;
    conf_weights = '0;
    dram_clk     = 1'b1;
    repeat (reset_cycles) @(negedge reset);
    dram_clk = 1'b0;
    repeat (2) @(negedge reset);

    // Row 2 col 5, earlier rows and columns must not start it
    configure(10'd2, 10'd5, 1'b1);
    stream_features(row_len, 1'b1);
    configure(10'd1, 10'd0, 1'b0);  // Busy, ignored
    stream_features(3 * row_len, 1'b0);
    wait_done();

    for (int p = 0; p < 4; p++) begin
      col = (p == 1) ? col_w'(row_len - patch_size) :
                       col_w'($unsigned($random(seed)) % (row_len - patch_size + 1));
      configure(m_row + 1'b1, col, 1'b1);
      stream_features(2 * row_len, 1'b0);
      wait_done();
    end

    // Restart mid row, then a row 0 patch in the new frame
    stream_features(10, 1'b0);
    configure(10'd0, 10'd3, 1'b1);
    stream_features(2 * row_len, 1'b1);
    wait_done();
    repeat (4) @(negedge reset);

    if (patches_seen != patches_expected) begin
      errors++;
      $display("Only %0d of %0d patches finished", patches_seen, patches_expected);
    end
    total_errors = errors + u_dut.u_props.prop_errors;
    $display("Closing report: %0d testbench errors, %0d property errors",
             errors, u_dut.u_props.prop_errors);
    if (total_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    while (cyc < max_cycles) @(posedge reset);
    $display("Run stopped after %0d cycles without finishing", cyc);
    $display("Closing report: %0d testbench errors, %0d property errors",
             errors, u_dut.u_props.prop_errors);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
source/patch_pkg.sv
source/scan_position.sv
source/patch_weight_bank.sv
source/patch_mac.sv
source/patch_row_reducer.sv
source/patch_reducer_top.sv
test/patch_reducer_properties.sv
test/patch_reducer_tb.sv

// File: Bender.yml
package:
  name: patch_reducer

sources:
  - files:
      - source/patch_pkg.sv
      - source/scan_position.sv
      - source/patch_weight_bank.sv
      - source/patch_mac.sv
      - source/patch_row_reducer.sv
      - source/patch_reducer_top.sv
  - target: test
    files:
      - test/patch_reducer_properties.sv
      - test/patch_reducer_tb.sv
